// File: source/buf_share_pkg.sv
// all widths fixed here; two beats per row and no tag bits, so addresses are plain indices
package buf_share_pkg;

  // memory side beat and array side row
  localparam int MEM_W         = 64;
  localparam int ROW_W         = 128;
  localparam int BEATS_PER_ROW = ROW_W / MEM_W;

  // depth shared by ibuf and obuf
  localparam int ROWS          = 16;
  localparam int ROW_AW        = $clog2(ROWS);

  // beat address is {row, half}, low bit picks the half
  localparam int BEAT_AW       = ROW_AW + $clog2(BEATS_PER_ROW);

  // one row word, seen flat by the array or as beats by the memory side
  // beat[0] is the low half
  typedef union packed {
    logic [ROW_W-1:0]                    row;
    logic [BEATS_PER_ROW-1:0][MEM_W-1:0] beat;
  } ibuf_row_u;

endpackage

// File: source/buf_req_if.sv
// registered requests of the owning client; every req is a one-cycle strobe, no handshake
`timescale 1ns/1ps

interface buf_req_if
  import buf_share_pkg::*;
  ();

  // ibuf, beat write and row read
  logic               ibuf_wr_req;
  logic [BEAT_AW-1:0] ibuf_wr_addr;
  logic [MEM_W-1:0]   ibuf_wr_data;
  logic               ibuf_rd_req;
  logic [ROW_AW-1:0]  ibuf_rd_addr;

  // obuf, row write and beat read
  logic               obuf_wr_req;
  logic [ROW_AW-1:0]  obuf_wr_addr;
  logic [ROW_W-1:0]   obuf_wr_data;
  logic               obuf_rd_req;
  logic [BEAT_AW-1:0] obuf_rd_addr;

  // 1 while the cnn engine owns the buffers
  logic               owner_cnn;

  modport src (
    output ibuf_wr_req, ibuf_wr_addr, ibuf_wr_data, ibuf_rd_req, ibuf_rd_addr,
    output obuf_wr_req, obuf_wr_addr, obuf_wr_data, obuf_rd_req, obuf_rd_addr,
    output owner_cnn
  );

  modport dst (
    input ibuf_wr_req, ibuf_wr_addr, ibuf_wr_data, ibuf_rd_req, ibuf_rd_addr,
    input obuf_wr_req, obuf_wr_addr, obuf_wr_data, obuf_rd_req, obuf_rd_addr,
    input owner_cnn
  );

endinterface

// File: source/rd_data_if.sv
// store read returns; each valid is a single-cycle pulse with its data, one cycle after the req
`timescale 1ns/1ps

interface rd_data_if
  import buf_share_pkg::*;
  ();

  logic [ROW_W-1:0] ibuf_rd_data;
  logic             ibuf_rd_valid;
  logic [MEM_W-1:0] obuf_rd_data;
  logic             obuf_rd_valid;

  modport src (
    output ibuf_rd_data, ibuf_rd_valid,
    output obuf_rd_data, obuf_rd_valid
  );

  modport dst (
    input ibuf_rd_data, ibuf_rd_valid,
    input obuf_rd_data, obuf_rd_valid
  );

endinterface

// File: source/client_select.sv
// cnn_sel is a level sampled each edge; unselected client inputs are dropped, never queued
`timescale 1ns/1ps

module client_select
  import buf_share_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               cnn_sel,
  input  logic               cnn_ibuf_wr_req,
  input  logic [BEAT_AW-1:0] cnn_ibuf_wr_addr,
  input  logic [MEM_W-1:0]   cnn_ibuf_wr_data,
  input  logic               cnn_ibuf_rd_req,
  input  logic [ROW_AW-1:0]  cnn_ibuf_rd_addr,
  input  logic               cnn_obuf_wr_req,
  input  logic [ROW_AW-1:0]  cnn_obuf_wr_addr,
  input  logic [ROW_W-1:0]   cnn_obuf_wr_data,
  input  logic               cnn_obuf_rd_req,
  input  logic [BEAT_AW-1:0] cnn_obuf_rd_addr,
  input  logic               lidar_ibuf_wr_req,
  input  logic [BEAT_AW-1:0] lidar_ibuf_wr_addr,
  input  logic [MEM_W-1:0]   lidar_ibuf_wr_data,
  input  logic               lidar_ibuf_rd_req,
  input  logic [ROW_AW-1:0]  lidar_ibuf_rd_addr,
  input  logic               lidar_obuf_wr_req,
  input  logic [ROW_AW-1:0]  lidar_obuf_wr_addr,
  input  logic [ROW_W-1:0]   lidar_obuf_wr_data,
  input  logic               lidar_obuf_rd_req,
  input  logic [BEAT_AW-1:0] lidar_obuf_rd_addr,
  buf_req_if.src             req
);

  // strobes and owner flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req.ibuf_wr_req <= 1'b0;
      req.ibuf_rd_req <= 1'b0;
      req.obuf_wr_req <= 1'b0;
      req.obuf_rd_req <= 1'b0;
      req.owner_cnn   <= 1'b1;
    end else begin
      req.ibuf_wr_req <= cnn_sel ? cnn_ibuf_wr_req : lidar_ibuf_wr_req;
      req.ibuf_rd_req <= cnn_sel ? cnn_ibuf_rd_req : lidar_ibuf_rd_req;
      req.obuf_wr_req <= cnn_sel ? cnn_obuf_wr_req : lidar_obuf_wr_req;
      req.obuf_rd_req <= cnn_sel ? cnn_obuf_rd_req : lidar_obuf_rd_req;
      req.owner_cnn   <= cnn_sel;
    end
  end

  // address and data, only meaningful under a strobe
  always_ff @(posedge clk) begin
    req.ibuf_wr_addr <= cnn_sel ? cnn_ibuf_wr_addr : lidar_ibuf_wr_addr;
    req.ibuf_wr_data <= cnn_sel ? cnn_ibuf_wr_data : lidar_ibuf_wr_data;
    req.ibuf_rd_addr <= cnn_sel ? cnn_ibuf_rd_addr : lidar_ibuf_rd_addr;
    req.obuf_wr_addr <= cnn_sel ? cnn_obuf_wr_addr : lidar_obuf_wr_addr;
    req.obuf_wr_data <= cnn_sel ? cnn_obuf_wr_data : lidar_obuf_wr_data;
    req.obuf_rd_addr <= cnn_sel ? cnn_obuf_rd_addr : lidar_obuf_rd_addr;
  end

endmodule

// File: source/ibuf_store.sv
// RAM contents are not reset; a read colliding with a write to the same row returns old data
`timescale 1ns/1ps

module ibuf_store
  import buf_share_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  buf_req_if.dst req,
  rd_data_if.src rd
);

  ibuf_row_u mem [ROWS];

  logic [ROW_AW-1:0]          wr_row;
  logic [BEAT_AW-ROW_AW-1:0]  wr_half;

  // upper bits pick the row, low bit the half
  assign wr_row  = req.ibuf_wr_addr[BEAT_AW-1:BEAT_AW-ROW_AW];
  assign wr_half = req.ibuf_wr_addr[BEAT_AW-ROW_AW-1:0];

  // beat write leaves the other half untouched
  always_ff @(posedge clk) begin
    if (req.ibuf_wr_req) begin
      mem[wr_row].beat[wr_half] <= req.ibuf_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (req.ibuf_rd_req) begin
      rd.ibuf_rd_data <= mem[req.ibuf_rd_addr].row;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd.ibuf_rd_valid <= 1'b0;
    end else begin
      rd.ibuf_rd_valid <= req.ibuf_rd_req;
    end
  end

endmodule

// File: source/obuf_store.sv
// RAM contents are not reset; a read colliding with a write to the same row returns old data
`timescale 1ns/1ps

module obuf_store
  import buf_share_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  buf_req_if.dst req,
  rd_data_if.src rd
);

  ibuf_row_u mem [ROWS];

  logic [ROW_AW-1:0]          rd_row;
  logic [BEAT_AW-ROW_AW-1:0]  rd_half;

  assign rd_row  = req.obuf_rd_addr[BEAT_AW-1:BEAT_AW-ROW_AW];
  assign rd_half = req.obuf_rd_addr[BEAT_AW-ROW_AW-1:0];

  // full accumulated row from the array
  always_ff @(posedge clk) begin
    if (req.obuf_wr_req) begin
      mem[req.obuf_wr_addr].row <= req.obuf_wr_data;
    end
  end

  // narrow readback, half 0 first
  always_ff @(posedge clk) begin
    if (req.obuf_rd_req) begin
      rd.obuf_rd_data <= mem[rd_row].beat[rd_half];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd.obuf_rd_valid <= 1'b0;
    end else begin
      rd.obuf_rd_valid <= req.obuf_rd_req;
    end
  end

endmodule

// File: source/read_return_router.sv
// returns land only at the issuing client; the other client's output holds its last value
`timescale 1ns/1ps

module read_return_router
  import buf_share_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  buf_req_if.dst           req,
  rd_data_if.dst           rd,
  output logic [ROW_W-1:0] cnn_ibuf_rd_data,
  output logic [ROW_W-1:0] lidar_ibuf_rd_data,
  output logic [MEM_W-1:0] cnn_obuf_rd_data,
  output logic [MEM_W-1:0] lidar_obuf_rd_data
);

  // owner of the cycle the store read was performed in
  logic owner_cnn_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owner_cnn_q <= 1'b1;
    end else begin
      owner_cnn_q <= req.owner_cnn;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnn_ibuf_rd_data   <= '0;
      lidar_ibuf_rd_data <= '0;
      cnn_obuf_rd_data   <= '0;
      lidar_obuf_rd_data <= '0;
    end else begin
      if (rd.ibuf_rd_valid) begin
        if (owner_cnn_q) begin
          cnn_ibuf_rd_data <= rd.ibuf_rd_data;
        end else begin
          lidar_ibuf_rd_data <= rd.ibuf_rd_data;
        end
      end
      if (rd.obuf_rd_valid) begin
        if (owner_cnn_q) begin
          cnn_obuf_rd_data <= rd.obuf_rd_data;
        end else begin
          lidar_obuf_rd_data <= rd.obuf_rd_data;
        end
      end
    end
  end

endmodule

// File: source/buf_share_top.sv
// read data appears 2 cycles after the request is sampled; no back-pressure, nothing refused
`timescale 1ns/1ps

module buf_share_top
  import buf_share_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               cnn_sel,
  input  logic               cnn_ibuf_wr_req,
  input  logic [BEAT_AW-1:0] cnn_ibuf_wr_addr,
  input  logic [MEM_W-1:0]   cnn_ibuf_wr_data,
  input  logic               cnn_ibuf_rd_req,
  input  logic [ROW_AW-1:0]  cnn_ibuf_rd_addr,
  input  logic               cnn_obuf_wr_req,
  input  logic [ROW_AW-1:0]  cnn_obuf_wr_addr,
  input  logic [ROW_W-1:0]   cnn_obuf_wr_data,
  input  logic               cnn_obuf_rd_req,
  input  logic [BEAT_AW-1:0] cnn_obuf_rd_addr,
  input  logic               lidar_ibuf_wr_req,
  input  logic [BEAT_AW-1:0] lidar_ibuf_wr_addr,
  input  logic [MEM_W-1:0]   lidar_ibuf_wr_data,
  input  logic               lidar_ibuf_rd_req,
  input  logic [ROW_AW-1:0]  lidar_ibuf_rd_addr,
  input  logic               lidar_obuf_wr_req,
  input  logic [ROW_AW-1:0]  lidar_obuf_wr_addr,
  input  logic [ROW_W-1:0]   lidar_obuf_wr_data,
  input  logic               lidar_obuf_rd_req,
  input  logic [BEAT_AW-1:0] lidar_obuf_rd_addr,
  output logic [ROW_W-1:0]   cnn_ibuf_rd_data,
  output logic [ROW_W-1:0]   lidar_ibuf_rd_data,
  output logic [MEM_W-1:0]   cnn_obuf_rd_data,
  output logic [MEM_W-1:0]   lidar_obuf_rd_data
);

  buf_req_if req_bus ();
  rd_data_if rd_bus ();

  // input side
  client_select u_client_select (
    .clk                (clk),
    .arst_n             (arst_n),
    .cnn_sel            (cnn_sel),
    .cnn_ibuf_wr_req    (cnn_ibuf_wr_req),
    .cnn_ibuf_wr_addr   (cnn_ibuf_wr_addr),
    .cnn_ibuf_wr_data   (cnn_ibuf_wr_data),
    .cnn_ibuf_rd_req    (cnn_ibuf_rd_req),
    .cnn_ibuf_rd_addr   (cnn_ibuf_rd_addr),
    .cnn_obuf_wr_req    (cnn_obuf_wr_req),
    .cnn_obuf_wr_addr   (cnn_obuf_wr_addr),
    .cnn_obuf_wr_data   (cnn_obuf_wr_data),
    .cnn_obuf_rd_req    (cnn_obuf_rd_req),
    .cnn_obuf_rd_addr   (cnn_obuf_rd_addr),
    .lidar_ibuf_wr_req  (lidar_ibuf_wr_req),
    .lidar_ibuf_wr_addr (lidar_ibuf_wr_addr),
    .lidar_ibuf_wr_data (lidar_ibuf_wr_data),
    .lidar_ibuf_rd_req  (lidar_ibuf_rd_req),
    .lidar_ibuf_rd_addr (lidar_ibuf_rd_addr),
    .lidar_obuf_wr_req  (lidar_obuf_wr_req),
    .lidar_obuf_wr_addr (lidar_obuf_wr_addr),
    .lidar_obuf_wr_data (lidar_obuf_wr_data),
    .lidar_obuf_rd_req  (lidar_obuf_rd_req),
    .lidar_obuf_rd_addr (lidar_obuf_rd_addr),
    .req                (req_bus)
  );

  // shared stores
  ibuf_store u_ibuf_store (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req_bus),
    .rd     (rd_bus)
  );

  obuf_store u_obuf_store (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req_bus),
    .rd     (rd_bus)
  );

  // output side
  read_return_router u_read_return_router (
    .clk                (clk),
    .arst_n             (arst_n),
    .req                (req_bus),
    .rd                 (rd_bus),
    .cnn_ibuf_rd_data   (cnn_ibuf_rd_data),
    .lidar_ibuf_rd_data (lidar_ibuf_rd_data),
    .cnn_obuf_rd_data   (cnn_obuf_rd_data),
    .lidar_obuf_rd_data (lidar_obuf_rd_data)
  );

endmodule

// File: verif/buf_share_assert.sv
// watches the registered request strobes and store valids inside buf_share_top
`timescale 1ns/1ps

module buf_share_assert (
  input logic clk,
  input logic arst_n,
  input logic ibuf_rd_req,
  input logic ibuf_rd_valid,
  input logic obuf_rd_req,
  input logic obuf_rd_valid
);

  // valid is the request delayed by exactly one cycle
  ibuf_valid_follows_req: assert property (
    @(posedge clk) disable iff (!arst_n) ibuf_rd_valid == $past(ibuf_rd_req)
  ) else $error("ibuf_rd_valid does not follow ibuf_rd_req by one cycle");

  obuf_valid_follows_req: assert property (
    @(posedge clk) disable iff (!arst_n) obuf_rd_valid == $past(obuf_rd_req)
  ) else $error("obuf_rd_valid does not follow obuf_rd_req by one cycle");

  no_valid_after_reset: assert property (
    @(posedge clk) $rose(arst_n) |-> !ibuf_rd_valid && !obuf_rd_valid
  ) else $error("read valid high in the first cycle after reset release");

endmodule

bind buf_share_top buf_share_assert u_buf_share_assert (
  .clk           (clk),
  .arst_n        (arst_n),
  .ibuf_rd_req   (req_bus.ibuf_rd_req),
  .ibuf_rd_valid (rd_bus.ibuf_rd_valid),
  .obuf_rd_req   (req_bus.obuf_rd_req),
  .obuf_rd_valid (rd_bus.obuf_rd_valid)
);

// File: verif/tb_buf_share.sv
// run from the project root so verif/buf_share_stimulus.txt resolves; reads land 2 cycles late
`timescale 1ns/1ps

module tb_buf_share
  import buf_share_pkg::*;
();

  localparam int RST_CYCLES = 10;
  localparam int WAIT_LIMIT = 100;
  localparam int MAX_OPS    = 1000;

  typedef enum int {OP_NOP, OP_SEL, OP_IW, OP_IR, OP_OW, OP_OR, OP_BAD} op_e;

  logic               clk                = 1'b0;
  logic               arst_n             = 1'b0;
  logic               cnn_sel            = 1'b1;
  logic               cnn_ibuf_wr_req    = 1'b0;
  logic [BEAT_AW-1:0] cnn_ibuf_wr_addr   = '0;
  logic [MEM_W-1:0]   cnn_ibuf_wr_data   = '0;
  logic               cnn_ibuf_rd_req    = 1'b0;
  logic [ROW_AW-1:0]  cnn_ibuf_rd_addr   = '0;
  logic               cnn_obuf_wr_req    = 1'b0;
  logic [ROW_AW-1:0]  cnn_obuf_wr_addr   = '0;
  logic [ROW_W-1:0]   cnn_obuf_wr_data   = '0;
  logic               cnn_obuf_rd_req    = 1'b0;
  logic [BEAT_AW-1:0] cnn_obuf_rd_addr   = '0;
  logic               lidar_ibuf_wr_req  = 1'b0;
  logic [BEAT_AW-1:0] lidar_ibuf_wr_addr = '0;
  logic [MEM_W-1:0]   lidar_ibuf_wr_data = '0;
  logic               lidar_ibuf_rd_req  = 1'b0;
  logic [ROW_AW-1:0]  lidar_ibuf_rd_addr = '0;
  logic               lidar_obuf_wr_req  = 1'b0;
  logic [ROW_AW-1:0]  lidar_obuf_wr_addr = '0;
  logic [ROW_W-1:0]   lidar_obuf_wr_data = '0;
  logic               lidar_obuf_rd_req  = 1'b0;
  logic [BEAT_AW-1:0] lidar_obuf_rd_addr = '0;
  logic [ROW_W-1:0]   cnn_ibuf_rd_data;
  logic [ROW_W-1:0]   lidar_ibuf_rd_data;
  logic [MEM_W-1:0]   cnn_obuf_rd_data;
  logic [MEM_W-1:0]   lidar_obuf_rd_data;

  int                 errors;
  int                 timeouts;
  int                 neg_cnt;
  bit                 sel_cnn        = 1'b1;
  logic [ROW_W-1:0]   exp_cnn_ibuf   = '0;
  logic [ROW_W-1:0]   exp_lidar_ibuf = '0;
  logic [MEM_W-1:0]   exp_cnn_obuf   = '0;
  logic [MEM_W-1:0]   exp_lidar_obuf = '0;

  // reads in flight, oldest first
  int                 due_q[$];
  bit                 obuf_q[$];
  bit                 cnn_q[$];
  logic [ROW_W-1:0]   data_q[$];

  buf_share_top DUT (.*);

  initial begin
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

  task automatic check_value(input string name, input logic [ROW_W-1:0] act,
                             input logic [ROW_W-1:0] exp);
    assert (act === exp) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic op_e decode_op(input logic [63:0] tok);
    case (tok)
      64'("nop"): return OP_NOP;
      64'("sel"): return OP_SEL;
      64'("iw"):  return OP_IW;
      64'("ir"):  return OP_IR;
      64'("ow"):  return OP_OW;
      64'("or"):  return OP_OR;
      default:    return OP_BAD;
    endcase
  endfunction

  // one operation per cycle, strobes rebuilt from zero each time
  task automatic drive_op(input op_e op, input bit by_cnn, input logic [7:0] addr,
                          input logic [ROW_W-1:0] data);
    @(posedge clk);
    cnn_sel           <= sel_cnn;
    cnn_ibuf_wr_req   <= by_cnn && op == OP_IW;
    cnn_ibuf_rd_req   <= by_cnn && op == OP_IR;
    cnn_obuf_wr_req   <= by_cnn && op == OP_OW;
    cnn_obuf_rd_req   <= by_cnn && op == OP_OR;
    lidar_ibuf_wr_req <= !by_cnn && op == OP_IW;
    lidar_ibuf_rd_req <= !by_cnn && op == OP_IR;
    lidar_obuf_wr_req <= !by_cnn && op == OP_OW;
    lidar_obuf_rd_req <= !by_cnn && op == OP_OR;
    if (by_cnn) begin
      cnn_ibuf_wr_addr <= addr[BEAT_AW-1:0];
      cnn_ibuf_wr_data <= data[MEM_W-1:0];
      cnn_ibuf_rd_addr <= addr[ROW_AW-1:0];
      cnn_obuf_wr_addr <= addr[ROW_AW-1:0];
      cnn_obuf_wr_data <= data;
      cnn_obuf_rd_addr <= addr[BEAT_AW-1:0];
    end else begin
      lidar_ibuf_wr_addr <= addr[BEAT_AW-1:0];
      lidar_ibuf_wr_data <= data[MEM_W-1:0];
      lidar_ibuf_rd_addr <= addr[ROW_AW-1:0];
      lidar_obuf_wr_addr <= addr[ROW_AW-1:0];
      lidar_obuf_wr_data <= data;
      lidar_obuf_rd_addr <= addr[BEAT_AW-1:0];
    end
    // sampled next edge, loaded 2 edges later, seen at the 4th negedge from now
    if ((op == OP_IR || op == OP_OR) && by_cnn == sel_cnn) begin
      due_q.push_back(neg_cnt + 4);
      obuf_q.push_back(op == OP_OR);
      cnn_q.push_back(by_cnn);
      data_q.push_back(data);
    end
  endtask

  // outputs are compared every falling edge once reset is released
  initial begin
    forever begin
      @(negedge clk);
      neg_cnt++;
      while (due_q.size() > 0 && due_q[0] <= neg_cnt) begin
        if (obuf_q[0]) begin
          if (cnn_q[0]) begin
            exp_cnn_obuf = data_q[0][MEM_W-1:0];
          end else begin
            exp_lidar_obuf = data_q[0][MEM_W-1:0];
          end
        end else if (cnn_q[0]) begin
          exp_cnn_ibuf = data_q[0];
        end else begin
          exp_lidar_ibuf = data_q[0];
        end
        void'(due_q.pop_front());
        void'(obuf_q.pop_front());
        void'(cnn_q.pop_front());
        void'(data_q.pop_front());
      end
      if (arst_n === 1'b1) begin
        check_value("cnn_ibuf_rd_data", cnn_ibuf_rd_data, exp_cnn_ibuf);
        check_value("lidar_ibuf_rd_data", lidar_ibuf_rd_data, exp_lidar_ibuf);
        check_value("cnn_obuf_rd_data", {64'h0, cnn_obuf_rd_data}, {64'h0, exp_cnn_obuf});
        check_value("lidar_obuf_rd_data", {64'h0, lidar_obuf_rd_data},
                    {64'h0, exp_lidar_obuf});
      end
    end
  end

  initial begin
    int               fd;
    int               n;
    int               ops;
    int               waited;
    int               ch;
    logic [63:0]      tok;
    logic [63:0]      client;
    logic [7:0]       addr;
    logic [ROW_W-1:0] data;
    op_e              op;
    waited = 0;
    while (arst_n !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      $display("timeout: reset was not released within %0d cycles", WAIT_LIMIT);
      timeouts++;
    end else begin
      fd = $fopen("verif/buf_share_stimulus.txt", "r");
      if (fd == 0) begin
        $display("could not open verif/buf_share_stimulus.txt");
        errors++;
      end else begin
        ops = 0;
        n = $fscanf(fd, "%s", tok);
        while (n == 1 && ops < MAX_OPS) begin
          if (tok == 64'("#")) begin
            ch = $fgetc(fd);
            while (ch != 10 && ch != -1) begin
              ch = $fgetc(fd);
            end
          end else begin
            n = $fscanf(fd, "%s %h %h", client, addr, data);
            op = decode_op(tok);
            if (n != 3 || op == OP_BAD) begin
              $display("malformed stimulus line starting with %s", tok);
              errors++;
            end else if (op == OP_SEL) begin
              sel_cnn = (client == 64'("cnn"));
            end else begin
              drive_op(op, client == 64'("cnn"), addr, data);
            end
            ops++;
          end
          n = $fscanf(fd, "%s", tok);
        end
        if (n == 1) begin
          $display("timeout: stimulus file did not end within %0d operations", MAX_OPS);
          timeouts++;
        end
        $fclose(fd);
        drive_op(OP_NOP, 1'b1, 8'h0, '0);
        waited = 0;
        while (due_q.size() > 0 && waited < WAIT_LIMIT) begin
          @(posedge clk);
          waited++;
        end
        if (due_q.size() > 0) begin
          $display("timeout: %0d reads never completed", due_q.size());
          timeouts++;
        end
      end
    end
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verif/buf_share_stimulus.txt
# op: iw/ir ibuf write/read, ow/or obuf write/read, sel owner change, nop idle cycle
# columns: op client addr(hex) data(hex), data is write data or expected read data
sel cnn 0 0
iw cnn 06 1111aaaa2222bbbb
iw cnn 07 3333cccc4444dddd
ir cnn 3 3333cccc4444dddd1111aaaa2222bbbb
iw cnn 07 5555eeee6666ffff
ir cnn 3 5555eeee6666ffff1111aaaa2222bbbb
ow cnn 5 0123456789abcdeffedcba9876543210
or cnn 0a fedcba9876543210
or cnn 0b 0123456789abcdef
nop cnn 0 0
# lidar writes and reads while cnn owns the buffers
iw lidar 06 deaddeaddeaddead
ow lidar 5 deadbeefdeadbeefdeadbeefdeadbeef
ir lidar 3 0
ir cnn 3 5555eeee6666ffff1111aaaa2222bbbb
or cnn 0a fedcba9876543210
# lidar takes over the shared contents
sel lidar 0 0
ir lidar 3 5555eeee6666ffff1111aaaa2222bbbb
or lidar 0b 0123456789abcdef
iw lidar 10 0a0a0a0a0a0a0a0a
iw lidar 11 0b0b0b0b0b0b0b0b
ow lidar 9 99999999aaaaaaaa8888888877777777
iw cnn 10 ffffffffffffffff
sel cnn 0 0
ir cnn 8 0b0b0b0b0b0b0b0b0a0a0a0a0a0a0a0a
or cnn 12 8888888877777777
or cnn 13 99999999aaaaaaaa
# back to back reads with the owner alternating every cycle
sel lidar 0 0
ir lidar 8 0b0b0b0b0b0b0b0b0a0a0a0a0a0a0a0a
sel cnn 0 0
ir cnn 3 5555eeee6666ffff1111aaaa2222bbbb
sel lidar 0 0
or lidar 12 8888888877777777
sel cnn 0 0
or cnn 0a fedcba9876543210

// File: compile.f
source/buf_share_pkg.sv
source/buf_req_if.sv
source/rd_data_if.sv
source/client_select.sv
source/ibuf_store.sv
source/obuf_store.sv
source/read_return_router.sv
source/buf_share_top.sv
verif/buf_share_assert.sv
verif/tb_buf_share.sv

// File: run_sim.sh
#!/bin/sh
# builds with Verilator and runs from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_buf_share -f compile.f \
  -Mdir obj_dir -o sim_tb_buf_share > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb_buf_share > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
